// File: design/hps_proto_pkg.sv
/*
 * host bus protocol definitions: command codes, word widths,
 * the bus input struct and the decoded frame struct
 */
package hps_proto_pkg;

	localparam int io_word_w  = 16;
	localparam int word_idx_w = 10;

	////////////////////////////////////////////////////////////
	// command codes, first word of a frame
	////////////////////////////////////////////////////////////
	localparam logic [7:0] cmd_cfg        = 8'h01;
	localparam logic [7:0] cmd_joy0       = 8'h02;
	localparam logic [7:0] cmd_joy1       = 8'h03;
	localparam logic [7:0] cmd_sd_status  = 8'h16;
	localparam logic [7:0] cmd_sd_write   = 8'h17;
	localparam logic [7:0] cmd_sd_read    = 8'h18;
	localparam logic [7:0] cmd_status     = 8'h1E;
	localparam logic [7:0] cmd_status_set = 8'h29;
	localparam logic [7:0] cmd_file_tx    = 8'h53;
	localparam logic [7:0] cmd_file_data  = 8'h54;
	localparam logic [7:0] cmd_file_index = 8'h55;

	// upper nibble of the status-set count word
	localparam logic [3:0] status_set_tag = 4'hA;

	typedef struct packed {
		logic                 enable;
		logic                 strobe;
		logic [io_word_w-1:0] din;
	} hps_bus_in_t;

	// one strobed word as seen by the data modules
	typedef struct packed {
		logic                  word_stb;
		logic                  cmd_stb;
		logic [7:0]            cmd;
		logic [word_idx_w-1:0] idx;
		logic [io_word_w-1:0]  din;
		logic                  frame_end;
	} hps_frame_t;

endpackage

// File: design/hps_target_pkg.sv
/*
 * core-side target definitions: drive slot count, sector buffer
 * and download widths, and the SD command word layout
 */
package hps_target_pkg;

	localparam int num_slots    = 4;
	localparam int slot_w       = 2;
	localparam int buff_addr_w  = 9;
	localparam int buff_data_w  = 8;
	localparam int ioctl_addr_w = 27;
	localparam int lba_w        = 32;

	localparam logic [3:0] sd_cmd_tag = 4'h5;

	////////////////////////////////////////////////////////////
	// SD command word, as the host reads it with 0x16
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [1:0] rsvd;
		// slots 3, 2, 1 from msb down
		logic [2:0] wr_hi;
		logic [2:0] rd_hi;
		logic [3:0] tag;
		logic       conf;
		logic       present;
		logic       wr0;
		logic       rd0;
	} sd_cmd_fields_t;

	// built by field in the arbiter, returned raw to the host
	typedef union packed {
		logic [15:0]    raw;
		sd_cmd_fields_t fields;
	} sd_cmd_u;

endpackage

// File: design/hps_word_counter.sv
/*
 * word index within a host frame, saturating
 */
`timescale 1ns/100ps

module hps_word_counter (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  hps_proto_pkg::hps_bus_in_t           bus_in,
	output logic [hps_proto_pkg::word_idx_w-1:0] idx
);
	import hps_proto_pkg::*;

	// index of the word currently on the bus, 0 is the command word
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			idx <= '0;
		end else if (!bus_in.enable) begin
			idx <= '0;
		end else if (bus_in.strobe && !(&idx)) begin
			idx <= idx + word_idx_w'(1);
		end
	end

endmodule

// File: design/hps_cmd_fsm.sv
/*
 * frame state machine: command latch, frame strobes, frame end
 * pulse and the io_dout readback register
 */
`timescale 1ns/100ps

module hps_cmd_fsm (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  hps_proto_pkg::hps_bus_in_t           bus_in,
	input  logic [hps_proto_pkg::word_idx_w-1:0] idx,
	input  logic [hps_proto_pkg::io_word_w-1:0]  settings_rd,
	input  logic [hps_proto_pkg::io_word_w-1:0]  sd_rd_word,
	input  logic [hps_proto_pkg::io_word_w-1:0]  buff_rd,
	output hps_proto_pkg::hps_frame_t            frame,
	output logic [hps_proto_pkg::io_word_w-1:0]  io_dout
);
	import hps_proto_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_cmd,
		st_data
	} state_t;

	state_t     state;
	logic [7:0] cmd_q;
	logic       frame_end_q;
	logic       word_in;
	logic       first_word;

	assign word_in    = bus_in.enable && bus_in.strobe;
	// first strobe of a frame is the command, even if enable rose with it
	assign first_word = word_in && (state != st_data);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state       <= st_idle;
			cmd_q       <= '0;
			frame_end_q <= 1'b0;
		end else begin
			frame_end_q <= !bus_in.enable && (state != st_idle);
			if (first_word) begin
				cmd_q <= bus_in.din[7:0];
			end
			case (state)
				st_idle: if (bus_in.enable) state <= bus_in.strobe ? st_data : st_cmd;
				st_cmd: begin
					if (!bus_in.enable) state <= st_idle;
					else if (bus_in.strobe) state <= st_data;
				end
				st_data: if (!bus_in.enable) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// frame strobes follow the bus strobe in the same cycle
	////////////////////////////////////////////////////////////
	always_comb begin
		frame.cmd_stb   = first_word;
		frame.word_stb  = word_in && (state == st_data);
		frame.cmd       = first_word ? bus_in.din[7:0] : cmd_q;
		frame.idx       = idx;
		frame.din       = bus_in.din;
		frame.frame_end = frame_end_q;
	end

	// readback, each source is zero unless it owns cmd and idx
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			io_dout <= '0;
		end else if (!bus_in.enable) begin
			io_dout <= '0;
		end else if (bus_in.strobe) begin
			io_dout <= settings_rd | sd_rd_word | buff_rd;
		end
	end

endmodule

// File: design/hps_settings_regs.sv
/*
 * config byte, joysticks 0 and 1, 32-bit status and the
 * core-initiated status-set capture with its readback
 */
`timescale 1ns/100ps

module hps_settings_regs (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  hps_proto_pkg::hps_frame_t           frame,
	input  logic [31:0]                         status_in,
	input  logic                                status_set,
	output logic [1:0]                          buttons,
	output logic                                forced_scandoubler,
	output logic [31:0]                         joystick_0,
	output logic [31:0]                         joystick_1,
	output logic [31:0]                         status,
	output logic [hps_proto_pkg::io_word_w-1:0] rd_word
);
	import hps_proto_pkg::*;

	logic        status_set_q;
	logic [3:0]  set_count;
	logic [31:0] status_req;
	logic        word1;

	assign word1 = frame.word_stb && (frame.idx == word_idx_w'(1));

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			buttons            <= '0;
			forced_scandoubler <= 1'b0;
			joystick_0         <= '0;
			joystick_1         <= '0;
			status             <= '0;
			status_set_q       <= 1'b0;
			set_count          <= '0;
			status_req         <= '0;
		end else begin
			// rising edge of status_set from the core
			status_set_q <= status_set;
			if (status_set && !status_set_q) begin
				set_count  <= set_count + 4'd1;
				status_req <= status_in;
			end

			if (frame.word_stb) begin
				case (frame.cmd)
					cmd_cfg: if (word1) begin
						buttons            <= frame.din[1:0];
						forced_scandoubler <= frame.din[4];
					end
					// low half on word 1, high half on every later word
					cmd_joy0: begin
						if (word1) joystick_0[15:0] <= frame.din;
						else joystick_0[31:16] <= frame.din;
					end
					cmd_joy1: begin
						if (word1) joystick_1[15:0] <= frame.din;
						else joystick_1[31:16] <= frame.din;
					end
					cmd_status: begin
						if (word1) status[15:0] <= frame.din;
						else if (frame.idx == word_idx_w'(2)) status[31:16] <= frame.din;
					end
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		rd_word = '0;
		if (frame.cmd == cmd_status_set) begin
			case (frame.idx)
				0: rd_word = {8'h00, status_set_tag, set_count};
				1: rd_word = status_req[15:0];
				2: rd_word = status_req[31:16];
				default: rd_word = '0;
			endcase
		end
	end

endmodule

// File: design/sd_slot_arbiter.sv
/*
 * drive slot arbitration, SD status readback (0x16) and the
 * per-slot acknowledge over sector frames
 */
`timescale 1ns/100ps

module sd_slot_arbiter (
	input  logic                                     clk_sys,
	input  logic                                     reset,
	input  hps_proto_pkg::hps_frame_t                frame,
	input  logic                                     status_reset,
	input  logic [hps_target_pkg::num_slots-1:0]     sd_rd,
	input  logic [hps_target_pkg::num_slots-1:0]     sd_wr,
	input  logic [hps_target_pkg::num_slots-1:0][hps_target_pkg::lba_w-1:0] sd_lba,
	output logic [hps_target_pkg::num_slots-1:0]     sd_ack,
	output logic [hps_proto_pkg::io_word_w-1:0]      rd_word
);
	import hps_proto_pkg::*;
	import hps_target_pkg::*;

	logic                 slot_busy;
	logic [slot_w-1:0]    slot_sel;
	logic [num_slots-1:0] slot_mask;
	logic [num_slots-1:0] ack_q;
	logic                 req_any;
	logic [slot_w-1:0]    req_slot;
	logic [lba_w-1:0]     lba_sel;
	sd_cmd_u              cmd_word;

	// lowest slot wins, rd before wr within a slot
	always_comb begin
		req_any  = 1'b0;
		req_slot = '0;
		for (int i = num_slots - 1; i >= 0; i--) begin
			if (sd_rd[i] || sd_wr[i]) begin
				req_any  = 1'b1;
				req_slot = slot_w'(i);
			end
		end
	end

	always_comb begin
		for (int i = 0; i < num_slots; i++) begin
			slot_mask[i] = slot_busy && (slot_sel == slot_w'(i));
		end
	end

	////////////////////////////////////////////////////////////
	// grant, acknowledge and release
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			slot_busy <= 1'b0;
			slot_sel  <= '0;
			sd_ack    <= '0;
			ack_q     <= '0;
		end else begin
			ack_q <= sd_ack;
			if (status_reset) begin
				slot_busy <= 1'b0;
				sd_ack    <= '0;
			end else begin
				if (!slot_busy && req_any) begin
					slot_busy <= 1'b1;
					slot_sel  <= req_slot;
				end else if (|(ack_q & ~sd_ack)) begin
					// falling edge of the ack frees the slot
					slot_busy <= 1'b0;
				end
				if (frame.cmd_stb &&
				    (frame.cmd == cmd_sd_write || frame.cmd == cmd_sd_read)) begin
					sd_ack <= slot_mask;
				end else if (frame.frame_end) begin
					sd_ack <= '0;
				end
			end
		end
	end

	// only the active slot shows its requests
	always_comb begin
		cmd_word                = '0;
		cmd_word.fields.wr_hi   = sd_wr[3:1] & slot_mask[3:1];
		cmd_word.fields.rd_hi   = sd_rd[3:1] & slot_mask[3:1];
		cmd_word.fields.tag     = sd_cmd_tag;
		cmd_word.fields.conf    = 1'b0;
		cmd_word.fields.present = 1'b1;
		cmd_word.fields.wr0     = sd_wr[0] & slot_mask[0];
		cmd_word.fields.rd0     = sd_rd[0] & slot_mask[0];
	end

	assign lba_sel = sd_lba[slot_sel];

	always_comb begin
		rd_word = '0;
		if (frame.cmd == cmd_sd_status) begin
			case (frame.idx)
				1: rd_word = cmd_word.raw;
				2: rd_word = lba_sel[15:0];
				3: rd_word = lba_sel[31:16];
				default: rd_word = '0;
			endcase
		end
	end

endmodule

// File: design/sd_buffer_port.sv
/*
 * sector buffer port: address counter, write pulse and read data
 */
`timescale 1ns/100ps

module sd_buffer_port (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	input  hps_proto_pkg::hps_frame_t               frame,
	input  logic [hps_target_pkg::buff_data_w-1:0]  sd_buff_din,
	output logic [hps_target_pkg::buff_addr_w-1:0]  sd_buff_addr,
	output logic [hps_target_pkg::buff_data_w-1:0]  sd_buff_dout,
	output logic                                    sd_buff_wr,
	output logic [hps_proto_pkg::io_word_w-1:0]     rd_word
);
	import hps_proto_pkg::*;
	import hps_target_pkg::*;

	logic wr_word;
	logic rd_byte;

	assign wr_word = frame.word_stb && (frame.cmd == cmd_sd_write);
	assign rd_byte = frame.word_stb && (frame.cmd == cmd_sd_read);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			sd_buff_addr <= '0;
			sd_buff_dout <= '0;
			sd_buff_wr   <= 1'b0;
		end else begin
			sd_buff_wr <= wr_word;
			if (wr_word) sd_buff_dout <= frame.din[buff_data_w-1:0];
			if (frame.cmd_stb) begin
				sd_buff_addr <= '0;
			end else if ((sd_buff_wr || rd_byte) && !(&sd_buff_addr)) begin
				// write steps after its pulse, read steps with the strobe
				sd_buff_addr <= sd_buff_addr + buff_addr_w'(1);
			end
		end
	end

	assign rd_word = (frame.cmd == cmd_sd_read && frame.idx != '0) ?
		io_word_w'(sd_buff_din) : '0;

endmodule

// File: design/ioctl_loader.sv
/*
 * file download: download flag, file index, byte address and
 * the one-cycle write pulse towards the core
 */
`timescale 1ns/100ps

module ioctl_loader (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	input  hps_proto_pkg::hps_frame_t               frame,
	output logic                                    ioctl_download,
	output logic [7:0]                              ioctl_index,
	output logic                                    ioctl_wr,
	output logic [hps_target_pkg::ioctl_addr_w-1:0] ioctl_addr,
	output logic [hps_target_pkg::buff_data_w-1:0]  ioctl_dout
);
	import hps_proto_pkg::*;
	import hps_target_pkg::*;

	// next byte address, published on each write and at the end
	logic [ioctl_addr_w-1:0] addr;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			addr           <= '0;
		end else begin
			ioctl_wr <= 1'b0;
			if (frame.word_stb) begin
				case (frame.cmd)
					cmd_file_tx: begin
						if (frame.din[7:0] != 8'h00) begin
							ioctl_download <= 1'b1;
							addr           <= '0;
						end else begin
							ioctl_download <= 1'b0;
							ioctl_addr     <= addr;
						end
					end
					cmd_file_data: begin
						ioctl_addr <= addr;
						ioctl_dout <= frame.din[buff_data_w-1:0];
						ioctl_wr   <= 1'b1;
						addr       <= addr + ioctl_addr_w'(1);
					end
					cmd_file_index: ioctl_index <= frame.din[7:0];
					default: ;
				endcase
			end
		end
	end

endmodule

// File: design/hps_io.sv
/*
 * host command bus top level: word counter, frame FSM,
 * settings, SD slots, sector buffer and file download
 */
`timescale 1ns/100ps

module hps_io (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	input  hps_proto_pkg::hps_bus_in_t              bus_in,
	output logic [hps_proto_pkg::io_word_w-1:0]     io_dout,
	// settings
	output logic [1:0]                              buttons,
	output logic                                    forced_scandoubler,
	output logic [31:0]                             joystick_0,
	output logic [31:0]                             joystick_1,
	output logic [31:0]                             status,
	input  logic [31:0]                             status_in,
	input  logic                                    status_set,
	// SD slots and sector buffer
	input  logic [hps_target_pkg::num_slots-1:0]    sd_rd,
	input  logic [hps_target_pkg::num_slots-1:0]    sd_wr,
	input  logic [hps_target_pkg::num_slots-1:0][hps_target_pkg::lba_w-1:0] sd_lba,
	output logic [hps_target_pkg::num_slots-1:0]    sd_ack,
	output logic [hps_target_pkg::buff_addr_w-1:0]  sd_buff_addr,
	output logic [hps_target_pkg::buff_data_w-1:0]  sd_buff_dout,
	input  logic [hps_target_pkg::buff_data_w-1:0]  sd_buff_din,
	output logic                                    sd_buff_wr,
	// download
	output logic                                    ioctl_download,
	output logic [7:0]                              ioctl_index,
	output logic                                    ioctl_wr,
	output logic [hps_target_pkg::ioctl_addr_w-1:0] ioctl_addr,
	output logic [hps_target_pkg::buff_data_w-1:0]  ioctl_dout
);
	import hps_proto_pkg::*;

	logic [word_idx_w-1:0] idx;
	hps_frame_t            frame;
	logic [io_word_w-1:0]  settings_rd;
	logic [io_word_w-1:0]  sd_rd_word;
	logic [io_word_w-1:0]  buff_rd;

	hps_word_counter hps_word_counter_inst (
		.clk_sys (clk_sys), .reset (reset), .bus_in (bus_in), .idx (idx)
	);

	hps_cmd_fsm hps_cmd_fsm_inst (
		.clk_sys (clk_sys), .reset (reset), .bus_in (bus_in), .idx (idx),
		.settings_rd (settings_rd), .sd_rd_word (sd_rd_word), .buff_rd (buff_rd),
		.frame (frame), .io_dout (io_dout)
	);

	hps_settings_regs hps_settings_regs_inst (
		.clk_sys (clk_sys), .reset (reset), .frame (frame),
		.status_in (status_in), .status_set (status_set),
		.buttons (buttons), .forced_scandoubler (forced_scandoubler),
		.joystick_0 (joystick_0), .joystick_1 (joystick_1),
		.status (status), .rd_word (settings_rd)
	);

	// status bit 0 is the host's reset of the drive slots
	sd_slot_arbiter sd_slot_arbiter_inst (
		.clk_sys (clk_sys), .reset (reset), .frame (frame),
		.status_reset (status[0]), .sd_rd (sd_rd), .sd_wr (sd_wr), .sd_lba (sd_lba),
		.sd_ack (sd_ack), .rd_word (sd_rd_word)
	);

	sd_buffer_port sd_buffer_port_inst (
		.clk_sys (clk_sys), .reset (reset), .frame (frame), .sd_buff_din (sd_buff_din),
		.sd_buff_addr (sd_buff_addr), .sd_buff_dout (sd_buff_dout),
		.sd_buff_wr (sd_buff_wr), .rd_word (buff_rd)
	);

	ioctl_loader ioctl_loader_inst (
		.clk_sys (clk_sys), .reset (reset), .frame (frame),
		.ioctl_download (ioctl_download), .ioctl_index (ioctl_index),
		.ioctl_wr (ioctl_wr), .ioctl_addr (ioctl_addr), .ioctl_dout (ioctl_dout)
	);

endmodule

// File: bench/hps_io_tb.sv
/*
 * testbench for the host command bus: host frame driver, sector
 * RAM model, download write monitor, directed tests and watchdog
 */
`timescale 1ns/100ps

module hps_io_tb;
	import hps_proto_pkg::*;
	import hps_target_pkg::*;

	localparam int clk_period   = 8;
	localparam int sector_bytes = 512;
	localparam int dl_bytes     = 20;
	// words per test including the command words
	localparam int total_words  = 11 + 3 + 11 + 2 * (sector_bytes + 1) + (dl_bytes + 7) + 12;
	localparam int total_frames = 18;
	// two cycles per word, open and close per frame, reset and request setup
	localparam int frame_cycles = 2 * total_words + 9 * total_frames + 32;
	localparam int watchdog_ns  = 2 * frame_cycles * clk_period;

	logic                            clk_sys;
	logic                            reset;
	hps_bus_in_t                     bus_in;
	logic [io_word_w-1:0]            io_dout;
	logic [1:0]                      buttons;
	logic                            forced_scandoubler;
	logic [31:0]                     joystick_0;
	logic [31:0]                     joystick_1;
	logic [31:0]                     status;
	logic [31:0]                     status_in;
	logic                            status_set;
	logic [num_slots-1:0]            sd_rd;
	logic [num_slots-1:0]            sd_wr;
	logic [num_slots-1:0][lba_w-1:0] sd_lba;
	logic [num_slots-1:0]            sd_ack;
	logic [buff_addr_w-1:0]          sd_buff_addr;
	logic [buff_data_w-1:0]          sd_buff_dout;
	logic [buff_data_w-1:0]          sd_buff_din;
	logic                            sd_buff_wr;
	logic                            ioctl_download;
	logic [7:0]                      ioctl_index;
	logic                            ioctl_wr;
	logic [ioctl_addr_w-1:0]         ioctl_addr;
	logic [buff_data_w-1:0]          ioctl_dout;

	int                      errors;
	int                      tests_run;
	int unsigned             rng_state;
	logic [15:0]             tx_q[$];
	logic [15:0]             rx_q[$];
	logic [7:0]              ram [0:sector_bytes-1];
	logic [num_slots-1:0]    ack_seen;
	int                      wr_count;
	logic [ioctl_addr_w-1:0] wr_addr_log [0:31];
	logic [7:0]              wr_data_log [0:31];

	hps_io hps_io_inst (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// core side models
	////////////////////////////////////////////////////////////
	assign sd_buff_din = ram[sd_buff_addr];

	// sector RAM model that writes on the edge ending the pulse
	always @(posedge clk_sys) begin
		if (sd_buff_wr) begin
			ram[sd_buff_addr] = sd_buff_dout;
		end
	end

	// acks and download writes seen by the core
	always @(posedge clk_sys) begin
		ack_seen = ack_seen | sd_ack;
		if (ioctl_wr) begin
			if (wr_count < 32) begin
				wr_addr_log[wr_count] = ioctl_addr;
				wr_data_log[wr_count] = ioctl_dout;
			end
			wr_count++;
		end
	end

	function automatic logic [15:0] lcg_next();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state[30:15];
	endfunction

	// 0x16 word one holds wr slots 3..1 at 13:11, rd slots 3..1 at 10:8,
	// tag at 7:4, presence at 2, wr0 at 1 and rd0 at 0
	function automatic logic [15:0] expected_sd_word(input logic [3:0] wr, input logic [3:0] rd);
		logic [15:0] w;
		w        = 16'h0000;
		w[13:11] = wr[3:1];
		w[10:8]  = rd[3:1];
		w[7:4]   = 4'h5;
		w[2]     = 1'b1;
		w[1]     = wr[0];
		w[0]     = rd[0];
		return w;
	endfunction

	task automatic flag_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
	endtask

	////////////////////////////////////////////////////////////
	// host bus driver
	////////////////////////////////////////////////////////////
	task automatic open_frame();
		@(negedge clk_sys);
		bus_in.enable = 1'b1;
	endtask

	// drives one strobed word and returns io_dout as the host reads it back
	task automatic send_word(input logic [15:0] w, output logic [15:0] rd);
		@(negedge clk_sys);
		bus_in.strobe = 1'b1;
		bus_in.din    = w;
		@(negedge clk_sys);
		bus_in.strobe = 1'b0;
		rd            = io_dout;
	endtask

	// idle covers frame end, ack fall, slot release and a new grant
	task automatic close_frame();
		@(negedge clk_sys);
		bus_in.enable = 1'b0;
		bus_in.din    = '0;
		repeat (6) @(negedge clk_sys);
	endtask

	task automatic run_frame();
		logic [15:0] rd;
		rx_q.delete();
		open_frame();
		foreach (tx_q[i]) begin
			send_word(tx_q[i], rd);
			rx_q.push_back(rd);
		end
		close_frame();
		tx_q.delete();
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////
	task automatic settings_writes();
		logic [15:0] w1;
		logic [15:0] w2;
		tests_run++;
		w1 = lcg_next();
		tx_q.push_back({8'h00, cmd_cfg});
		tx_q.push_back(w1);
		run_frame();
		if (buttons !== w1[1:0]) flag_mismatch("buttons", 32'(buttons), 32'(w1[1:0]));
		if (forced_scandoubler !== w1[4]) begin
			flag_mismatch("forced_scandoubler", 32'(forced_scandoubler), 32'(w1[4]));
		end

		w1 = lcg_next();
		w2 = lcg_next();
		tx_q.push_back({8'h00, cmd_joy0});
		tx_q.push_back(w1);
		tx_q.push_back(w2);
		run_frame();
		if (joystick_0 !== {w2, w1}) flag_mismatch("joystick_0", joystick_0, {w2, w1});

		w1 = lcg_next();
		w2 = lcg_next();
		tx_q.push_back({8'h00, cmd_joy1});
		tx_q.push_back(w1);
		tx_q.push_back(w2);
		run_frame();
		if (joystick_1 !== {w2, w1}) flag_mismatch("joystick_1", joystick_1, {w2, w1});

		// bit 0 stays low since it would hold the drive slots in reset
		w1 = lcg_next() & 16'hFFFE;
		w2 = lcg_next();
		tx_q.push_back({8'h00, cmd_status});
		tx_q.push_back(w1);
		tx_q.push_back(w2);
		run_frame();
		if (status !== {w2, w1}) flag_mismatch("status", status, {w2, w1});
	endtask

	task automatic status_set_capture();
		logic [31:0] v;
		int          n;
		tests_run++;
		n = 3;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {lcg_next(), lcg_next()};
			@(negedge clk_sys);
			status_in  = v;
			status_set = 1'b1;
			@(negedge clk_sys);
			status_set = 1'b0;
		end
		// later changes must not reach the captured value
		status_in = ~v;
		tx_q.push_back({8'h00, cmd_status_set});
		tx_q.push_back(16'h0000);
		tx_q.push_back(16'h0000);
		run_frame();
		if (rx_q[0] !== 16'h00A0 + 16'(n)) begin
			flag_mismatch("io_dout count word", 32'(rx_q[0]), 32'(16'h00A0 + 16'(n)));
		end
		if (rx_q[1] !== v[15:0]) flag_mismatch("io_dout word 1", 32'(rx_q[1]), 32'(v[15:0]));
		if (rx_q[2] !== v[31:16]) flag_mismatch("io_dout word 2", 32'(rx_q[2]), 32'(v[31:16]));
	endtask

	task automatic slot_arbitration();
		logic [15:0] rd;
		tests_run++;
		for (int i = 0; i < num_slots; i++) begin
			sd_lba[i] = {lcg_next(), lcg_next()};
		end
		sd_rd = 4'b0100;
		sd_wr = 4'b0010;
		repeat (2) @(negedge clk_sys);

		tx_q.push_back({8'h00, cmd_sd_status});
		repeat (3) tx_q.push_back(16'h0000);
		run_frame();
		if (rx_q[1] !== expected_sd_word(4'b0010, 4'b0000)) begin
			flag_mismatch("sd command word", 32'(rx_q[1]),
				32'(expected_sd_word(4'b0010, 4'b0000)));
		end
		if (rx_q[2] !== sd_lba[1][15:0]) begin
			flag_mismatch("lba low", 32'(rx_q[2]), 32'(sd_lba[1][15:0]));
		end
		if (rx_q[3] !== sd_lba[1][31:16]) begin
			flag_mismatch("lba high", 32'(rx_q[3]), 32'(sd_lba[1][31:16]));
		end

		ack_seen = '0;
		open_frame();
		send_word({8'h00, cmd_sd_read}, rd);
		if (sd_ack !== 4'b0010) flag_mismatch("sd_ack", 32'(sd_ack), 32'h2);
		// the core drops its request once acknowledged
		sd_wr = 4'b0000;
		send_word(16'h0000, rd);
		send_word(16'h0000, rd);
		close_frame();
		if (ack_seen !== 4'b0010) flag_mismatch("sd_ack seen", 32'(ack_seen), 32'h2);
		if (sd_ack !== 4'b0000) flag_mismatch("sd_ack after frame", 32'(sd_ack), 32'h0);

		// slot 1 is released and slot 2 is next
		tx_q.push_back({8'h00, cmd_sd_status});
		repeat (3) tx_q.push_back(16'h0000);
		run_frame();
		if (rx_q[1] !== expected_sd_word(4'b0000, 4'b0100)) begin
			flag_mismatch("sd command word", 32'(rx_q[1]),
				32'(expected_sd_word(4'b0000, 4'b0100)));
		end
		if (rx_q[2] !== sd_lba[2][15:0]) begin
			flag_mismatch("lba low", 32'(rx_q[2]), 32'(sd_lba[2][15:0]));
		end
		if (rx_q[3] !== sd_lba[2][31:16]) begin
			flag_mismatch("lba high", 32'(rx_q[3]), 32'(sd_lba[2][31:16]));
		end
	endtask

	task automatic sector_buffer_roundtrip();
		logic [7:0]  bytes [0:sector_bytes-1];
		logic [15:0] w;
		tests_run++;
		tx_q.push_back({8'h00, cmd_sd_write});
		for (int i = 0; i < sector_bytes; i++) begin
			w        = lcg_next();
			bytes[i] = w[7:0];
			tx_q.push_back(w);
		end
		run_frame();
		for (int i = 0; i < sector_bytes; i++) begin
			if (ram[i] !== bytes[i]) begin
				flag_mismatch($sformatf("ram[%0d]", i), 32'(ram[i]), 32'(bytes[i]));
			end
		end

		tx_q.push_back({8'h00, cmd_sd_read});
		repeat (sector_bytes) tx_q.push_back(16'h0000);
		run_frame();
		for (int i = 0; i < sector_bytes; i++) begin
			if (rx_q[i + 1] !== {8'h00, bytes[i]}) begin
				flag_mismatch($sformatf("io_dout byte %0d", i), 32'(rx_q[i + 1]), 32'(bytes[i]));
			end
		end
	endtask

	task automatic file_download();
		logic [7:0]  data [0:dl_bytes-1];
		logic [15:0] w;
		tests_run++;
		w = lcg_next();
		tx_q.push_back({8'h00, cmd_file_index});
		tx_q.push_back({8'h00, w[7:0]});
		run_frame();
		if (ioctl_index !== w[7:0]) flag_mismatch("ioctl_index", 32'(ioctl_index), 32'(w[7:0]));

		tx_q.push_back({8'h00, cmd_file_tx});
		tx_q.push_back(16'h0001);
		run_frame();
		if (ioctl_download !== 1'b1) flag_mismatch("ioctl_download", 32'(ioctl_download), 32'h1);

		wr_count = 0;
		tx_q.push_back({8'h00, cmd_file_data});
		for (int i = 0; i < dl_bytes; i++) begin
			w       = lcg_next();
			data[i] = w[7:0];
			tx_q.push_back(w);
		end
		run_frame();
		if (wr_count !== dl_bytes) flag_mismatch("ioctl_wr pulses", 32'(wr_count), 32'(dl_bytes));
		for (int i = 0; i < dl_bytes; i++) begin
			if (wr_addr_log[i] !== ioctl_addr_w'(i)) begin
				flag_mismatch("ioctl_addr", 32'(wr_addr_log[i]), 32'(i));
			end
			if (wr_data_log[i] !== data[i]) begin
				flag_mismatch("ioctl_dout", 32'(wr_data_log[i]), 32'(data[i]));
			end
		end

		tx_q.push_back({8'h00, cmd_file_tx});
		tx_q.push_back(16'h0000);
		run_frame();
		if (ioctl_download !== 1'b0) flag_mismatch("ioctl_download", 32'(ioctl_download), 32'h0);
		if (ioctl_addr !== ioctl_addr_w'(dl_bytes)) begin
			flag_mismatch("ioctl_addr final", 32'(ioctl_addr), 32'(dl_bytes));
		end
	endtask

	task automatic slot_reset_by_status();
		tests_run++;
		// slot 2 still requests and holds the grant
		tx_q.push_back({8'h00, cmd_sd_status});
		tx_q.push_back(16'h0000);
		run_frame();
		if (rx_q[1] !== expected_sd_word(4'b0000, 4'b0100)) begin
			flag_mismatch("sd command word", 32'(rx_q[1]),
				32'(expected_sd_word(4'b0000, 4'b0100)));
		end

		tx_q.push_back({8'h00, cmd_status});
		tx_q.push_back(16'h0001);
		tx_q.push_back(16'h0000);
		run_frame();

		tx_q.push_back({8'h00, cmd_sd_status});
		repeat (3) tx_q.push_back(16'h0000);
		run_frame();
		if (rx_q[1] !== expected_sd_word(4'b0000, 4'b0000)) begin
			flag_mismatch("sd command word", 32'(rx_q[1]),
				32'(expected_sd_word(4'b0000, 4'b0000)));
		end

		ack_seen = '0;
		tx_q.push_back({8'h00, cmd_sd_read});
		repeat (2) tx_q.push_back(16'h0000);
		run_frame();
		if (ack_seen !== 4'b0000) flag_mismatch("sd_ack seen", 32'(ack_seen), 32'h0);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////
	initial begin
		errors     = 0;
		tests_run  = 0;
		rng_state  = 19841;
		ack_seen   = '0;
		wr_count   = 0;
		reset      = 1'b1;
		bus_in     = '0;
		status_in  = '0;
		status_set = 1'b0;
		sd_rd      = '0;
		sd_wr      = '0;
		sd_lba     = '0;
		// fill uses every address bit
		for (int i = 0; i < sector_bytes; i++) begin
			ram[i] = 8'((i * 37) ^ (i >> 1));
		end
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		settings_writes();
		status_set_capture();
		slot_arbitration();
		sector_buffer_roundtrip();
		file_download();
		slot_reset_by_status();

		$display("tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("timeout: the tests did not finish within %0d ns", watchdog_ns);
		$display("tests run: %0d, errors: %0d", tests_run, errors);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: project.f
design/hps_proto_pkg.sv
design/hps_target_pkg.sv
design/hps_word_counter.sv
design/hps_cmd_fsm.sv
design/hps_settings_regs.sv
design/sd_slot_arbiter.sv
design/sd_buffer_port.sv
design/ioctl_loader.sv
design/hps_io.sv
bench/hps_io_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the hps_io testbench with Verilator, run it, then search the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! verilator --binary --timing --top-module hps_io_tb -f project.f \
	--Mdir "$build_dir" -o hps_io_tb; then
	echo "verilator compile failed"
	exit 1
fi

"./$build_dir/hps_io_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Done: no errors" "$log_file"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
